// File: src/mips_pkg.sv
package mips_pkg;

   localparam int NB_WORD     = 32;
   localparam int NB_REG_ADDR = 5;
   localparam int NB_OPCODE   = 6;
   localparam int NB_FUNCT    = 6;
   localparam int NB_IMM      = 16;
   localparam int NB_JIDX     = 26;
   localparam int N_REGS      = 32;

   localparam int IMEM_DEPTH   = 512;
   localparam int DMEM_DEPTH   = 256;
   localparam int NB_IMEM_ADDR = $clog2(IMEM_DEPTH);
   localparam int NB_DMEM_ADDR = $clog2(DMEM_DEPTH);

   // instruction field positions
   localparam int MSB_OPCODE = 31;
   localparam int MSB_RS     = 25;
   localparam int MSB_RT     = 20;
   localparam int MSB_RD     = 15;

   typedef logic [NB_WORD-1:0]      word_t;
   typedef logic [NB_REG_ADDR-1:0]  reg_addr_t;
   typedef logic [NB_WORD-1:0]      pc_t;
   typedef logic [NB_IMEM_ADDR-1:0] imem_addr_t;
   typedef logic [NB_DMEM_ADDR-1:0] dmem_addr_t;
   typedef logic [NB_OPCODE-1:0]    opcode_t;
   typedef logic [NB_FUNCT-1:0]     funct_t;

   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI} alu_op_t;

   localparam word_t NOP = '0;

   localparam opcode_t OP_RTYPE = 6'h00;
   localparam opcode_t OP_J     = 6'h02;
   localparam opcode_t OP_BEQ   = 6'h04;
   localparam opcode_t OP_BNE   = 6'h05;
   localparam opcode_t OP_ADDI  = 6'h08;
   localparam opcode_t OP_ORI   = 6'h0d;
   localparam opcode_t OP_LUI   = 6'h0f;
   localparam opcode_t OP_LW    = 6'h23;
   localparam opcode_t OP_SW    = 6'h2b;

   localparam funct_t FN_JR   = 6'h08;
   localparam funct_t FN_ADDU = 6'h21;
   localparam funct_t FN_SUBU = 6'h23;
   localparam funct_t FN_AND  = 6'h24;
   localparam funct_t FN_OR   = 6'h25;
   localparam funct_t FN_SLT  = 6'h2a;

endpackage

// File: src/instruction_fetch.sv
`timescale 1ns/1ps

module instruction_fetch import mips_pkg::*; (
   input  logic       i_clock,
   input  logic       i_rst_n,
   input  logic       i_valid,
   input  logic       i_stall,
   input  logic       i_redirect,
   input  pc_t        i_target,
   input  logic       i_imem_we,
   input  imem_addr_t i_imem_addr,
   input  word_t      i_imem_data,
   output word_t      o_instr,
   output pc_t        o_pc4,
   output pc_t        o_pc
);

   word_t imem [IMEM_DEPTH];
   pc_t   pc;
   pc_t   pc_plus4;
   word_t fetched;

   assign pc_plus4 = pc + pc_t'(4);
   assign fetched  = imem[pc[NB_IMEM_ADDR+1:2]];
   assign o_pc     = pc;

   // program load port, only usable while frozen
   always_ff @(posedge i_clock) begin
      if (i_imem_we && !i_valid) begin
         imem[i_imem_addr] <= i_imem_data;
      end
   end

   // pc and instruction half of IF/ID
   always_ff @(posedge i_clock) begin
      if (!i_rst_n) begin
         pc      <= '0;
         o_instr <= NOP;
      end else if (i_valid) begin
         if (i_redirect) begin
            pc      <= i_target;
            o_instr <= NOP;
         end else if (!i_stall) begin
            pc      <= pc_plus4;
            o_instr <= fetched;
         end
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_valid && !i_stall) begin
         o_pc4 <= pc_plus4;
      end
   end

   a_imem_write_frozen: assert property (@(posedge i_clock) disable iff (!i_rst_n)
      i_imem_we |-> !i_valid);

endmodule

// File: src/instruction_decode.sv
`timescale 1ns/1ps

module instruction_decode import mips_pkg::*; (
   input  logic      i_clock,
   input  logic      i_rst_n,
   input  logic      i_valid,
   input  word_t     i_instr,
   input  pc_t       i_pc4,
   input  logic      i_stall,
   input  logic      i_wb_we,
   input  reg_addr_t i_wb_addr,
   input  word_t     i_wb_data,
   input  reg_addr_t i_dbg_addr,
   output alu_op_t   o_alu_op,
   output logic      o_use_imm,
   output logic      o_mem_rd,
   output logic      o_mem_wr,
   output logic      o_reg_we,
   output reg_addr_t o_rd,
   output word_t     o_a,
   output word_t     o_b,
   output word_t     o_imm,
   output reg_addr_t o_rs,
   output reg_addr_t o_rt,
   output logic      o_redirect,
   output pc_t       o_target,
   output word_t     o_dbg_data
);

   word_t              regs [N_REGS];
   opcode_t            opcode;
   funct_t             funct;
   reg_addr_t          rs;
   reg_addr_t          rt;
   reg_addr_t          rd_field;
   reg_addr_t          dest;
   logic [NB_IMM-1:0]  imm16;
   logic [NB_JIDX-1:0] jidx;
   word_t              val_a;
   word_t              val_b;
   word_t              imm_ext;
   logic               wb_wr;
   alu_op_t            alu_op;
   logic               use_imm;
   logic               sign_ext;
   logic               mem_rd;
   logic               mem_wr;
   logic               reg_we;
   logic               dest_rt;
   logic               taken;

   assign opcode   = i_instr[MSB_OPCODE -: NB_OPCODE];
   assign rs       = i_instr[MSB_RS -: NB_REG_ADDR];
   assign rt       = i_instr[MSB_RT -: NB_REG_ADDR];
   assign rd_field = i_instr[MSB_RD -: NB_REG_ADDR];
   assign funct    = i_instr[NB_FUNCT-1:0];
   assign imm16    = i_instr[NB_IMM-1:0];
   assign jidx     = i_instr[NB_JIDX-1:0];

   // write-first read, r0 never written so it reads zero
   assign wb_wr      = i_valid && i_wb_we && (i_wb_addr != '0);
   assign val_a      = (wb_wr && i_wb_addr == rs) ? i_wb_data : regs[rs];
   assign val_b      = (wb_wr && i_wb_addr == rt) ? i_wb_data : regs[rt];
   assign o_dbg_data = (wb_wr && i_wb_addr == i_dbg_addr) ? i_wb_data : regs[i_dbg_addr];

   assign imm_ext = sign_ext ? {{(NB_WORD-NB_IMM){imm16[NB_IMM-1]}}, imm16}
                             : {{(NB_WORD-NB_IMM){1'b0}}, imm16};
   assign dest       = dest_rt ? rt : rd_field;
   // held branch waits for the stall to clear
   assign o_redirect = taken && !i_stall;

   always_comb begin
      alu_op   = ALU_ADD;
      use_imm  = 1'b0;
      sign_ext = 1'b1;
      mem_rd   = 1'b0;
      mem_wr   = 1'b0;
      reg_we   = 1'b0;
      dest_rt  = 1'b0;
      taken    = 1'b0;
      o_target = i_pc4 + {{(NB_WORD-NB_IMM-2){imm16[NB_IMM-1]}}, imm16, 2'b00};
      case (opcode)
         OP_RTYPE: begin
            reg_we = 1'b1;
            case (funct)
               FN_ADDU: alu_op = ALU_ADD;
               FN_SUBU: alu_op = ALU_SUB;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_SLT:  alu_op = ALU_SLT;
               FN_JR: begin
                  reg_we   = 1'b0;
                  taken    = 1'b1;
                  o_target = val_a;
               end
               default: reg_we = 1'b0;
            endcase
         end
         OP_ADDI, OP_ORI, OP_LUI, OP_LW: begin
            use_imm  = 1'b1;
            reg_we   = 1'b1;
            dest_rt  = 1'b1;
            mem_rd   = (opcode == OP_LW);
            sign_ext = (opcode == OP_ADDI) || (opcode == OP_LW);
            if (opcode == OP_ORI) begin
               alu_op = ALU_OR;
            end else if (opcode == OP_LUI) begin
               alu_op = ALU_LUI;
            end
         end
         OP_SW: begin
            use_imm = 1'b1;
            mem_wr  = 1'b1;
         end
         OP_BEQ: taken = (val_a == val_b);
         OP_BNE: taken = (val_a != val_b);
         OP_J: begin
            taken    = 1'b1;
            o_target = {i_pc4[NB_WORD-1:NB_JIDX+2], jidx, 2'b00};
         end
         default: taken = 1'b0;
      endcase
   end

   always_ff @(posedge i_clock) begin
      if (!i_rst_n) begin
         for (int i = 0; i < N_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_wr) begin
         regs[i_wb_addr] <= i_wb_data;
      end
   end

   // ID/EX control, bubble on stall
   always_ff @(posedge i_clock) begin
      if (!i_rst_n) begin
         o_alu_op  <= ALU_ADD;
         o_use_imm <= 1'b0;
         o_mem_rd  <= 1'b0;
         o_mem_wr  <= 1'b0;
         o_reg_we  <= 1'b0;
         o_rd      <= '0;
         o_rs      <= '0;
         o_rt      <= '0;
      end else if (i_valid) begin
         o_alu_op  <= alu_op;
         o_use_imm <= use_imm;
         o_mem_rd  <= mem_rd && !i_stall;
         o_mem_wr  <= mem_wr && !i_stall;
         o_reg_we  <= reg_we && (dest != '0) && !i_stall;
         o_rd      <= dest;
         o_rs      <= rs;
         o_rt      <= rt;
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_valid) begin
         o_a   <= val_a;
         o_b   <= val_b;
         o_imm <= imm_ext;
      end
   end

   a_no_r0_write: assert property (@(posedge i_clock) disable iff (!i_rst_n)
      i_wb_we |-> (i_wb_addr != '0));

endmodule

// File: src/execution.sv
`timescale 1ns/1ps

module execution import mips_pkg::*; (
   input  logic      i_clock,
   input  logic      i_rst_n,
   input  logic      i_valid,
   input  alu_op_t   i_alu_op,
   input  logic      i_use_imm,
   input  logic      i_mem_rd,
   input  logic      i_mem_wr,
   input  logic      i_reg_we,
   input  reg_addr_t i_rd,
   input  word_t     i_a,
   input  word_t     i_b,
   input  word_t     i_imm,
   input  word_t     i_fwd_a,
   input  word_t     i_fwd_b,
   input  logic      i_sel_a,
   input  logic      i_sel_b,
   output word_t     o_alu,
   output word_t     o_store,
   output logic      o_mem_rd,
   output logic      o_mem_wr,
   output logic      o_reg_we,
   output reg_addr_t o_rd
);

   word_t op_a;
   word_t rt_val;
   word_t op_b;
   word_t result;

   assign op_a   = i_sel_a ? i_fwd_a : i_a;
   // rt value is also the store data
   assign rt_val = i_sel_b ? i_fwd_b : i_b;
   assign op_b   = i_use_imm ? i_imm : rt_val;

   always_comb begin
      case (i_alu_op)
         ALU_ADD: result = op_a + op_b;
         ALU_SUB: result = op_a - op_b;
         ALU_AND: result = op_a & op_b;
         ALU_OR:  result = op_a | op_b;
         ALU_SLT: result = word_t'($signed(op_a) < $signed(op_b));
         ALU_LUI: result = {op_b[NB_IMM-1:0], {NB_IMM{1'b0}}};
         default: result = '0;
      endcase
   end

   always_ff @(posedge i_clock) begin
      if (!i_rst_n) begin
         o_mem_rd <= 1'b0;
         o_mem_wr <= 1'b0;
         o_reg_we <= 1'b0;
         o_rd     <= '0;
      end else if (i_valid) begin
         o_mem_rd <= i_mem_rd;
         o_mem_wr <= i_mem_wr;
         o_reg_we <= i_reg_we;
         o_rd     <= i_rd;
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_valid) begin
         o_alu   <= result;
         o_store <= rt_val;
      end
   end

endmodule

// File: src/memory_access.sv
`timescale 1ns/1ps

module memory_access import mips_pkg::*; (
   input  logic      i_clock,
   input  logic      i_rst_n,
   input  logic      i_valid,
   input  word_t     i_alu,
   input  word_t     i_store,
   input  logic      i_mem_rd,
   input  logic      i_mem_wr,
   input  logic      i_reg_we,
   input  reg_addr_t i_rd,
   output logic      o_wb_we,
   output reg_addr_t o_wb_addr,
   output word_t     o_wb_data
);

   word_t      dmem [DMEM_DEPTH];
   dmem_addr_t idx;
   word_t      load_q;
   word_t      alu_q;
   logic       mem_rd_q;

   // word index from the byte address
   assign idx = i_alu[NB_DMEM_ADDR+1:2];

   always_ff @(posedge i_clock) begin
      if (!i_rst_n) begin
         for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] <= '0;
         end
      end else if (i_valid && i_mem_wr) begin
         dmem[idx] <= i_store;
      end
   end

   always_ff @(posedge i_clock) begin
      if (!i_rst_n) begin
         mem_rd_q  <= 1'b0;
         o_wb_we   <= 1'b0;
         o_wb_addr <= '0;
      end else if (i_valid) begin
         mem_rd_q  <= i_mem_rd;
         o_wb_we   <= i_reg_we;
         o_wb_addr <= i_rd;
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_valid) begin
         load_q <= dmem[idx];
         alu_q  <= i_alu;
      end
   end

   // writeback select
   assign o_wb_data = mem_rd_q ? load_q : alu_q;

   a_word_aligned: assert property (@(posedge i_clock) disable iff (!i_rst_n)
      (i_valid && (i_mem_rd || i_mem_wr)) |-> (i_alu[1:0] == 2'b00));

endmodule

// File: src/shortcircuit_unit.sv
`timescale 1ns/1ps

module shortcircuit_unit import mips_pkg::*; (
   input  reg_addr_t i_rs,
   input  reg_addr_t i_rt,
   input  reg_addr_t i_rd_ex,
   input  logic      i_we_ex,
   input  word_t     i_data_ex,
   input  reg_addr_t i_rd_mem,
   input  logic      i_we_mem,
   input  word_t     i_data_mem,
   output logic      o_sel_a,
   output logic      o_sel_b,
   output word_t     o_data_a,
   output word_t     o_data_b
);

   logic hit_ex_a;
   logic hit_ex_b;
   logic hit_mem_a;
   logic hit_mem_b;

   // r0 is never a forwarding source
   assign hit_ex_a  = i_we_ex  && (i_rd_ex  != '0) && (i_rd_ex  == i_rs);
   assign hit_ex_b  = i_we_ex  && (i_rd_ex  != '0) && (i_rd_ex  == i_rt);
   assign hit_mem_a = i_we_mem && (i_rd_mem != '0) && (i_rd_mem == i_rs);
   assign hit_mem_b = i_we_mem && (i_rd_mem != '0) && (i_rd_mem == i_rt);

   // newest producer wins
   assign o_sel_a  = hit_ex_a || hit_mem_a;
   assign o_sel_b  = hit_ex_b || hit_mem_b;
   assign o_data_a = hit_ex_a ? i_data_ex : i_data_mem;
   assign o_data_b = hit_ex_b ? i_data_ex : i_data_mem;

endmodule

// File: src/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import mips_pkg::*; (
   input  word_t     i_instr,
   input  reg_addr_t i_rd_ex,
   input  logic      i_mem_rd_ex,
   output logic      o_stall
);

   opcode_t   opcode;
   reg_addr_t rs;
   reg_addr_t rt;
   logic      reads_rt;

   assign opcode = i_instr[MSB_OPCODE -: NB_OPCODE];
   assign rs     = i_instr[MSB_RS -: NB_REG_ADDR];
   assign rt     = i_instr[MSB_RT -: NB_REG_ADDR];

   // rt is a source only for these formats
   assign reads_rt = (opcode == OP_RTYPE) || (opcode == OP_SW) ||
                     (opcode == OP_BEQ)   || (opcode == OP_BNE);

   assign o_stall = i_mem_rd_ex && (i_rd_ex != '0) &&
                    ((i_rd_ex == rs) || (reads_rt && (i_rd_ex == rt)));

endmodule

// File: src/pipeline.sv
`timescale 1ns/1ps

module pipeline import mips_pkg::*; (
   input  logic       i_clock,
   input  logic       i_rst_n,
   input  logic       i_valid,
   input  logic       i_imem_we,
   input  imem_addr_t i_imem_addr,
   input  word_t      i_imem_data,
   input  reg_addr_t  i_dbg_addr,
   output word_t      o_dbg_data,
   output pc_t        o_pc
);

   // fetch <-> decode
   word_t     if_instr;
   pc_t       if_pc4;
   logic      id_redirect;
   pc_t       id_target;
   logic      stall;

   // ID/EX
   alu_op_t   id_alu_op;
   logic      id_use_imm;
   logic      id_mem_rd;
   logic      id_mem_wr;
   logic      id_reg_we;
   reg_addr_t id_rd;
   word_t     id_a;
   word_t     id_b;
   word_t     id_imm;
   reg_addr_t id_rs;
   reg_addr_t id_rt;

   // forwarding
   logic      sc_sel_a;
   logic      sc_sel_b;
   word_t     sc_data_a;
   word_t     sc_data_b;

   // EX/MEM
   word_t     ex_alu;
   word_t     ex_store;
   logic      ex_mem_rd;
   logic      ex_mem_wr;
   logic      ex_reg_we;
   reg_addr_t ex_rd;

   // writeback into the register file
   logic      wb_we;
   reg_addr_t wb_addr;
   word_t     wb_data;

   instruction_fetch u_instruction_fetch (
      .i_clock(i_clock), .i_rst_n(i_rst_n), .i_valid(i_valid),
      .i_stall(stall), .i_redirect(id_redirect), .i_target(id_target),
      .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
      .o_instr(if_instr), .o_pc4(if_pc4), .o_pc(o_pc)
   );

   instruction_decode u_instruction_decode (
      .i_clock(i_clock), .i_rst_n(i_rst_n), .i_valid(i_valid),
      .i_instr(if_instr), .i_pc4(if_pc4), .i_stall(stall),
      .i_wb_we(wb_we), .i_wb_addr(wb_addr), .i_wb_data(wb_data), .i_dbg_addr(i_dbg_addr),
      .o_alu_op(id_alu_op), .o_use_imm(id_use_imm), .o_mem_rd(id_mem_rd),
      .o_mem_wr(id_mem_wr), .o_reg_we(id_reg_we), .o_rd(id_rd),
      .o_a(id_a), .o_b(id_b), .o_imm(id_imm), .o_rs(id_rs), .o_rt(id_rt),
      .o_redirect(id_redirect), .o_target(id_target), .o_dbg_data(o_dbg_data)
   );

   execution u_execution (
      .i_clock(i_clock), .i_rst_n(i_rst_n), .i_valid(i_valid),
      .i_alu_op(id_alu_op), .i_use_imm(id_use_imm), .i_mem_rd(id_mem_rd),
      .i_mem_wr(id_mem_wr), .i_reg_we(id_reg_we), .i_rd(id_rd),
      .i_a(id_a), .i_b(id_b), .i_imm(id_imm),
      .i_fwd_a(sc_data_a), .i_fwd_b(sc_data_b), .i_sel_a(sc_sel_a), .i_sel_b(sc_sel_b),
      .o_alu(ex_alu), .o_store(ex_store), .o_mem_rd(ex_mem_rd),
      .o_mem_wr(ex_mem_wr), .o_reg_we(ex_reg_we), .o_rd(ex_rd)
   );

   memory_access u_memory_access (
      .i_clock(i_clock), .i_rst_n(i_rst_n), .i_valid(i_valid),
      .i_alu(ex_alu), .i_store(ex_store), .i_mem_rd(ex_mem_rd),
      .i_mem_wr(ex_mem_wr), .i_reg_we(ex_reg_we), .i_rd(ex_rd),
      .o_wb_we(wb_we), .o_wb_addr(wb_addr), .o_wb_data(wb_data)
   );

   shortcircuit_unit u_shortcircuit_unit (
      .i_rs(id_rs), .i_rt(id_rt),
      .i_rd_ex(ex_rd), .i_we_ex(ex_reg_we), .i_data_ex(ex_alu),
      .i_rd_mem(wb_addr), .i_we_mem(wb_we), .i_data_mem(wb_data),
      .o_sel_a(sc_sel_a), .o_sel_b(sc_sel_b), .o_data_a(sc_data_a), .o_data_b(sc_data_b)
   );

   hazard_unit u_hazard_unit (
      .i_instr(if_instr), .i_rd_ex(id_rd), .i_mem_rd_ex(id_mem_rd), .o_stall(stall)
   );

endmodule

// File: tb/tb_pipeline.sv
`timescale 1ns/1ps

module tb_pipeline import mips_pkg::*; ();

   localparam int N_TESTS    = 5;
   localparam int PROG_LEN   = 16;
   localparam int MAX_EXP    = 8;
   localparam int CLK_PERIOD = 8;
   localparam int RUN_CYCLES = 40;

   logic       i_clock;
   logic       i_rst_n;
   logic       i_valid;
   logic       i_imem_we;
   imem_addr_t i_imem_addr;
   word_t      i_imem_data;
   reg_addr_t  i_dbg_addr;
   word_t      o_dbg_data;
   pc_t        o_pc;

   // test table
   word_t     prog [N_TESTS][PROG_LEN];
   reg_addr_t exp_reg [N_TESTS][MAX_EXP];
   word_t     exp_val [N_TESTS][MAX_EXP];
   int        n_exp [N_TESTS];
   int        run_len [N_TESTS];
   int        freeze_at [N_TESTS];
   int        freeze_len [N_TESTS];
   pc_t       exp_pc [N_TESTS];

   integer seed         = 32'h65c24b30;
   int     errors       = 0;
   int     limit_cycles = 0;

   pipeline pipeline_inst (
      .i_clock(i_clock), .i_rst_n(i_rst_n), .i_valid(i_valid),
      .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
      .i_dbg_addr(i_dbg_addr), .o_dbg_data(o_dbg_data), .o_pc(o_pc)
   );

   initial begin
      i_clock = 1'b0;
      forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
   end

   // instruction encoders for the ISA formats
   function automatic word_t r_format(funct_t fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
      return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic word_t i_format(opcode_t op, reg_addr_t rt, reg_addr_t rs,
                                      logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t j_format(logic [25:0] idx);
      return {OP_J, idx};
   endfunction

   task automatic set_expect(input int t, input reg_addr_t r, input word_t v);
      exp_reg[t][n_exp[t]] = r;
      exp_val[t][n_exp[t]] = v;
      n_exp[t]++;
   endtask

   // forwarding chain with random immediates
   task automatic build_random_entry(input int t);
      logic [15:0] r1;
      logic [15:0] r2;
      logic [15:0] r3;
      word_t       v [1:8];
      r1 = 16'($random(seed));
      r2 = 16'($random(seed));
      r3 = 16'($random(seed));
      v[1] = {{16{r1[15]}}, r1};
      v[2] = v[1] + {{16{r2[15]}}, r2};
      v[3] = v[1] | {16'h0, r3};
      v[4] = v[2] + v[3];
      v[5] = v[4] - v[2];
      v[6] = v[5] & v[4];
      v[7] = ($signed(v[6]) < $signed(v[5])) ? 32'd1 : 32'd0;
      v[8] = v[7] + v[6];
      prog[t][0] = i_format(OP_ADDI, 1, 0, r1);
      prog[t][1] = i_format(OP_ADDI, 2, 1, r2);
      prog[t][2] = i_format(OP_ORI, 3, 1, r3);
      prog[t][3] = r_format(FN_ADDU, 4, 2, 3);
      prog[t][4] = r_format(FN_SUBU, 5, 4, 2);
      prog[t][5] = r_format(FN_AND, 6, 5, 4);
      prog[t][6] = r_format(FN_SLT, 7, 6, 5);
      prog[t][7] = r_format(FN_ADDU, 8, 7, 6);
      for (int k = 1; k <= 8; k++) begin
         set_expect(t, reg_addr_t'(k), v[k]);
      end
   endtask

   task automatic build_table();
      for (int t = 0; t < N_TESTS; t++) begin
         for (int k = 0; k < PROG_LEN; k++) begin
            prog[t][k] = NOP;
         end
         n_exp[t]      = 0;
         run_len[t]    = RUN_CYCLES;
         freeze_at[t]  = 0;
         freeze_len[t] = 0;
         // final pc is 4 bytes per advancing cycle
         exp_pc[t]     = pc_t'(4 * RUN_CYCLES);
      end
      // ALU ops and immediates with sources three or more slots back
      prog[0][0]  = i_format(OP_ADDI, 1, 0, 16'd7);
      prog[0][1]  = i_format(OP_ADDI, 2, 0, 16'hfffd);
      prog[0][2]  = i_format(OP_LUI, 3, 0, 16'h1234);
      prog[0][3]  = i_format(OP_ORI, 4, 0, 16'hffff);
      prog[0][4]  = r_format(FN_ADDU, 5, 1, 2);
      prog[0][5]  = r_format(FN_SUBU, 6, 2, 1);
      prog[0][6]  = r_format(FN_AND, 7, 2, 4);
      prog[0][7]  = r_format(FN_OR, 8, 3, 1);
      prog[0][8]  = r_format(FN_SLT, 9, 2, 1);
      prog[0][9]  = i_format(OP_ADDI, 0, 0, 16'd5);
      prog[0][10] = r_format(FN_ADDU, 0, 1, 1);
      set_expect(0, 2, 32'hffff_fffd);
      set_expect(0, 3, 32'h1234_0000);
      set_expect(0, 5, 32'd4);
      set_expect(0, 6, 32'hffff_fff6);
      set_expect(0, 7, 32'h0000_fffd);
      set_expect(0, 8, 32'h1234_0007);
      set_expect(0, 9, 32'd1);
      set_expect(0, 0, 32'd0);
      build_random_entry(1);
      // store, reload and load-use
      prog[2][0]  = i_format(OP_ADDI, 1, 0, 16'd100);
      prog[2][1]  = i_format(OP_ADDI, 2, 0, 16'h0040);
      prog[2][2]  = i_format(OP_ADDI, 3, 0, 16'd7);
      prog[2][3]  = i_format(OP_SW, 1, 2, 16'd0);
      prog[2][4]  = i_format(OP_LW, 4, 2, 16'd0);
      prog[2][5]  = r_format(FN_ADDU, 5, 4, 3);
      prog[2][6]  = i_format(OP_ADDI, 6, 0, 16'd55);
      prog[2][7]  = i_format(OP_SW, 6, 2, 16'd4);
      prog[2][8]  = i_format(OP_LW, 7, 2, 16'd4);
      prog[2][9]  = i_format(OP_LW, 8, 2, 16'd0);
      prog[2][10] = r_format(FN_SUBU, 9, 8, 7);
      set_expect(2, 4, 32'd100);
      set_expect(2, 5, 32'd107);
      set_expect(2, 6, 32'd55);
      set_expect(2, 7, 32'd55);
      set_expect(2, 8, 32'd100);
      set_expect(2, 9, 32'd45);
      // two load-use stalls
      exp_pc[2] = pc_t'(4 * (RUN_CYCLES - 2));
      // branches and jumps with markers in r20..r27
      prog[3][0]  = i_format(OP_ADDI, 1, 0, 16'd5);
      prog[3][1]  = i_format(OP_ADDI, 2, 0, 16'd5);
      prog[3][2]  = i_format(OP_ADDI, 3, 0, 16'd9);
      prog[3][3]  = i_format(OP_ADDI, 10, 0, 16'h003c);
      prog[3][4]  = i_format(OP_BEQ, 2, 1, 16'd2);
      prog[3][5]  = i_format(OP_ADDI, 20, 0, 16'd1);
      prog[3][6]  = i_format(OP_ADDI, 21, 0, 16'd1);
      prog[3][7]  = i_format(OP_ADDI, 22, 0, 16'd1);
      prog[3][8]  = i_format(OP_BNE, 2, 1, 16'd3);
      prog[3][9]  = i_format(OP_ADDI, 23, 0, 16'd1);
      prog[3][10] = j_format(26'd12);
      prog[3][11] = i_format(OP_ADDI, 24, 0, 16'd1);
      prog[3][12] = r_format(FN_JR, 0, 10, 0);
      prog[3][13] = i_format(OP_ADDI, 25, 0, 16'd1);
      prog[3][14] = i_format(OP_ADDI, 26, 0, 16'd1);
      prog[3][15] = i_format(OP_ADDI, 27, 0, 16'd1);
      for (int k = 20; k <= 27; k++) begin
         set_expect(3, reg_addr_t'(k), (k == 22 || k == 23 || k == 27) ? 32'd1 : 32'd0);
      end
      // BEQ and JR each jump one word further than fall-through
      exp_pc[3] = pc_t'(4 * RUN_CYCLES + 8);
      // same program as entry 1 with a freeze in the middle
      for (int k = 0; k < PROG_LEN; k++) begin
         prog[4][k] = prog[1][k];
      end
      for (int k = 0; k < n_exp[1]; k++) begin
         set_expect(4, exp_reg[1][k], exp_val[1][k]);
      end
      freeze_at[4]  = 6;
      freeze_len[4] = 5;
      run_len[4]    = RUN_CYCLES + 5;
   endtask

   task automatic load_program(input int t);
      for (int a = 0; a < IMEM_DEPTH; a++) begin
         @(posedge i_clock);
         i_imem_we   <= 1'b1;
         i_imem_addr <= imem_addr_t'(a);
         i_imem_data <= (a < PROG_LEN) ? prog[t][a] : NOP;
      end
      @(posedge i_clock);
      i_imem_we <= 1'b0;
   endtask

   task automatic pulse_reset();
      @(posedge i_clock);
      i_rst_n <= 1'b0;
      repeat (16) @(posedge i_clock);
      i_rst_n <= 1'b1;
   endtask

   task automatic run_program(input int t);
      for (int c = 0; c < run_len[t]; c++) begin
         @(posedge i_clock);
         i_valid <= !(c >= freeze_at[t] && c < freeze_at[t] + freeze_len[t]);
      end
      @(posedge i_clock);
      i_valid <= 1'b0;
   endtask

   task automatic check_pc(input int t, input pc_t expected);
      @(negedge i_clock);
      assert (o_pc === expected) else begin
         errors++;
         $display("[ERROR] %0t: test %0d pc expected %h read %h",
                  $time, t, expected, o_pc);
         $display("Verification failed");
         $fatal(1, "pc mismatch");
      end
   endtask

   task automatic check_registers(input int t);
      for (int k = 0; k < n_exp[t]; k++) begin
         @(posedge i_clock);
         i_dbg_addr <= exp_reg[t][k];
         @(negedge i_clock);
         assert (o_dbg_data === exp_val[t][k]) else begin
            errors++;
            $display("[ERROR] %0t: test %0d r%0d expected %h read %h",
                     $time, t, exp_reg[t][k], exp_val[t][k], o_dbg_data);
            $display("Verification failed");
            $fatal(1, "register mismatch");
         end
      end
   endtask

   initial begin
      int budget;
      i_rst_n     <= 1'b0;
      i_valid     <= 1'b0;
      i_imem_we   <= 1'b0;
      i_imem_addr <= '0;
      i_imem_data <= '0;
      i_dbg_addr  <= '0;
      build_table();
      budget = 0;
      for (int t = 0; t < N_TESTS; t++) begin
         budget += IMEM_DEPTH + 18 + run_len[t] + 3 + 2 * MAX_EXP;
      end
      limit_cycles = 2 * budget;
      for (int t = 0; t < N_TESTS; t++) begin
         load_program(t);
         pulse_reset();
         check_pc(t, '0);
         run_program(t);
         check_pc(t, exp_pc[t]);
         check_registers(t);
      end
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      wait (limit_cycles > 0);
      #(limit_cycles * CLK_PERIOD);
      $display("simulation did not finish within %0d cycles", limit_cycles);
      $display("Verification failed");
      $fatal(1, "watchdog expired");
   end

endmodule

// File: pipeline.f
src/mips_pkg.sv
src/instruction_fetch.sv
src/instruction_decode.sv
src/execution.sv
src/memory_access.sv
src/shortcircuit_unit.sv
src/hazard_unit.sv
src/pipeline.sv
tb/tb_pipeline.sv
